// ==== logic/exu.sv ====
// execute and retire unit
module exu (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          dec_valid,
	input  logic [npc_pkg::xlen-1:0]      dec_pc,
	input  logic [npc_pkg::xlen-1:0]      dec_inst,
	input  npc_pkg::npc_op_e              dec_op,
	input  logic [npc_pkg::regaddr_w-1:0] dec_rd,
	input  logic [npc_pkg::regaddr_w-1:0] dec_rs1,
	input  logic [npc_pkg::regaddr_w-1:0] dec_rs2,
	input  logic [npc_pkg::xlen-1:0]      dec_imm,
	input  logic [npc_pkg::xlen-1:0]      rs1_data,
	input  logic [npc_pkg::xlen-1:0]      rs2_data,
	output logic                          dec_accept,
	output logic                          exu_busy,
	output logic                          rf_wen,
	output logic [npc_pkg::regaddr_w-1:0] rf_waddr,
	output logic [npc_pkg::xlen-1:0]      rf_wdata,
	output logic                          redirect_valid,
	output logic [npc_pkg::xlen-1:0]      next_pc,
	output logic                          retire_valid,
	output logic [npc_pkg::xlen-1:0]      retire_pc,
	output logic [npc_pkg::xlen-1:0]      retire_inst,
	output logic                          retire_wen,
	output logic [npc_pkg::regaddr_w-1:0] retire_rd,
	output logic [npc_pkg::xlen-1:0]      retire_wdata
);

	logic done;
	logic [npc_pkg::xlen-1:0] op_b;
	logic [npc_pkg::xlen-1:0] link;
	logic [npc_pkg::xlen-1:0] target;
	logic [npc_pkg::xlen-1:0] result;
	logic [npc_pkg::xlen-1:0] pc_nx;
	logic src_eq;

	assign dec_accept = dec_valid && !done;

	// i form arrives with rs2 as x0 and r form with a zero immediate
	assign op_b = (dec_rs2 == '0) ? dec_imm : rs2_data;
	assign link = dec_pc + 32'd4;
	assign target = dec_pc + dec_imm;
	assign src_eq = (rs1_data == rs2_data);

	always_comb begin
		result = '0;
		pc_nx = link;
		case (dec_op)
			npc_pkg::exe_add: result = rs1_data + op_b;
			npc_pkg::exe_sub: result = rs1_data - op_b;
			npc_pkg::exe_lui: result = dec_imm;
			npc_pkg::exe_jal: begin
				result = link;
				pc_nx = target;
			end
			npc_pkg::exe_beq: if (src_eq) pc_nx = target;
			npc_pkg::exe_bne: if (!src_eq) pc_nx = target;
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			done <= 1'b0;
			retire_wen <= 1'b0;
		end else begin
			done <= dec_accept;
			retire_wen <= dec_accept && (dec_rd != '0);
		end
	end

	always_ff @(posedge clk) begin
		if (dec_accept) begin
			retire_pc <= dec_pc;
			retire_inst <= dec_inst;
			retire_rd <= dec_rd;
			retire_wdata <= result;
			next_pc <= pc_nx;
		end
	end

	// retire, write back and redirect share one cycle
	assign retire_valid = done;
	assign redirect_valid = done;
	assign exu_busy = done;
	assign rf_wen = retire_wen;
	assign rf_waddr = retire_rd;
	assign rf_wdata = retire_wdata;

endmodule

// ==== logic/idu.sv ====
// instruction decode unit
module idu (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          fetch_valid,
	input  logic [npc_pkg::xlen-1:0]      fetch_pc,
	input  logic [npc_pkg::xlen-1:0]      fetch_inst,
	input  logic                          dec_accept,
	output logic                          dec_valid,
	output logic [npc_pkg::xlen-1:0]      dec_pc,
	output logic [npc_pkg::xlen-1:0]      dec_inst,
	output npc_pkg::npc_op_e              dec_op,
	output logic [npc_pkg::regaddr_w-1:0] dec_rd,
	output logic [npc_pkg::regaddr_w-1:0] dec_rs1,
	output logic [npc_pkg::regaddr_w-1:0] dec_rs2,
	output logic [npc_pkg::xlen-1:0]      dec_imm
);

	npc_pkg::npc_inst_u inst;
	npc_pkg::npc_op_e op_d;
	logic [npc_pkg::regaddr_w-1:0] rd_d;
	logic [npc_pkg::regaddr_w-1:0] rs2_d;
	logic [npc_pkg::xlen-1:0] imm_d;

	assign inst = fetch_inst;

	always_comb begin
		op_d = npc_pkg::exe_nop;
		rd_d = inst.r.rd;
		rs2_d = inst.r.rs2;
		imm_d = '0;
		case (inst.r.opcode)
			npc_pkg::op_reg: begin
				if (inst.r.funct3 == 3'b000 && inst.r.funct7 == 7'b0)
					op_d = npc_pkg::exe_add;
				else if (inst.r.funct3 == 3'b000 && inst.r.funct7 == npc_pkg::funct7_sub)
					op_d = npc_pkg::exe_sub;
			end
			npc_pkg::op_imm: begin
				// addi reads x0 as rs2 so exu takes the immediate
				if (inst.i.funct3 == 3'b000) begin
					op_d = npc_pkg::exe_add;
					rs2_d = '0;
					imm_d = {{20{inst.i.imm12[11]}}, inst.i.imm12};
				end
			end
			npc_pkg::op_lui: begin
				op_d = npc_pkg::exe_lui;
				imm_d = {inst.i.imm12, inst.i.rs1, inst.i.funct3, 12'b0};
			end
			npc_pkg::op_branch: begin
				if (inst.r.funct3 == npc_pkg::funct3_beq)
					op_d = npc_pkg::exe_beq;
				else if (inst.r.funct3 == npc_pkg::funct3_bne)
					op_d = npc_pkg::exe_bne;
				imm_d = npc_pkg::imm_b(fetch_inst);
			end
			npc_pkg::op_jal: begin
				op_d = npc_pkg::exe_jal;
				imm_d = npc_pkg::imm_j(fetch_inst);
			end
			default: begin
				op_d = npc_pkg::exe_nop;
			end
		endcase
		// no write for branches and anything unsupported
		if (op_d == npc_pkg::exe_nop || op_d == npc_pkg::exe_beq || op_d == npc_pkg::exe_bne)
			rd_d = '0;
	end

	always_ff @(posedge clk) begin
		if (rst)
			dec_valid <= 1'b0;
		else if (fetch_valid)
			dec_valid <= 1'b1;
		else if (dec_accept)
			dec_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (fetch_valid) begin
			dec_pc <= fetch_pc;
			dec_inst <= fetch_inst;
			dec_op <= op_d;
			dec_rd <= rd_d;
			dec_rs1 <= inst.r.rs1;
			dec_rs2 <= rs2_d;
			dec_imm <= imm_d;
		end
	end

endmodule

// ==== logic/ifu.sv ====
// instruction fetch unit
module ifu (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     imem_arready,
	input  logic                     imem_rvalid,
	input  logic [npc_pkg::xlen-1:0] imem_rdata,
	input  logic                     redirect_valid,
	input  logic [npc_pkg::xlen-1:0] next_pc,
	input  logic                     dec_valid,
	input  logic                     exu_busy,
	output logic [npc_pkg::xlen-1:0] imem_araddr,
	output logic                     imem_arvalid,
	output logic                     imem_rready,
	output logic                     fetch_valid,
	output logic [npc_pkg::xlen-1:0] fetch_pc,
	output logic [npc_pkg::xlen-1:0] fetch_inst
);

	logic [2:0] state;
	logic [2:0] state_nx;
	logic allow_in;
	logic [npc_pkg::xlen-1:0] pending_pc;
	logic [npc_pkg::xlen-1:0] araddr_r;
	logic [npc_pkg::xlen-1:0] inst_r;
	logic arvalid_r;
	logic rready_r;

	// one instruction in flight, so wait until decode and execute drain
	assign allow_in = (state == npc_pkg::ifu_idle) && !dec_valid && !exu_busy;

	always_comb begin
		state_nx = state;
		case (state)
			npc_pkg::ifu_idle: begin
				if (allow_in)
					state_nx = npc_pkg::ifu_wait_ar;
			end
			npc_pkg::ifu_wait_ar: begin
				// arvalid is high in this state
				if (imem_arready)
					state_nx = npc_pkg::ifu_shaked_ar;
			end
			npc_pkg::ifu_shaked_ar: begin
				if (imem_rvalid)
					state_nx = npc_pkg::ifu_shaked_r;
				else
					state_nx = npc_pkg::ifu_wait_r;
			end
			npc_pkg::ifu_wait_r: begin
				if (imem_rvalid)
					state_nx = npc_pkg::ifu_shaked_r;
			end
			npc_pkg::ifu_shaked_r: begin
				state_nx = npc_pkg::ifu_idle;
			end
			default: begin
				state_nx = npc_pkg::ifu_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= npc_pkg::ifu_idle;
		else
			state <= state_nx;
	end

	// channel outputs follow the state transition
	always_ff @(posedge clk) begin
		if (rst) begin
			arvalid_r <= 1'b0;
			rready_r <= 1'b0;
		end else begin
			arvalid_r <= (state_nx == npc_pkg::ifu_wait_ar);
			rready_r <= (state_nx == npc_pkg::ifu_shaked_ar) ||
				(state_nx == npc_pkg::ifu_wait_r);
		end
	end

	always_ff @(posedge clk) begin
		if (state == npc_pkg::ifu_idle && state_nx == npc_pkg::ifu_wait_ar)
			araddr_r <= pending_pc;
	end

	// capture on the data handshake
	always_ff @(posedge clk) begin
		if (state_nx == npc_pkg::ifu_shaked_r)
			inst_r <= imem_rdata;
	end

	// target of the last retire, or the boot address
	always_ff @(posedge clk) begin
		if (rst)
			pending_pc <= npc_pkg::reset_pc;
		else if (redirect_valid)
			pending_pc <= next_pc;
	end

	assign imem_araddr = araddr_r;
	assign imem_arvalid = arvalid_r;
	assign imem_rready = rready_r;

	assign fetch_valid = (state == npc_pkg::ifu_shaked_r);
	assign fetch_pc = araddr_r;
	assign fetch_inst = inst_r;

endmodule

// ==== logic/npc_core.sv ====
// npc core top level
module npc_core (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          imem_arready,
	input  logic                          imem_rvalid,
	input  logic [npc_pkg::xlen-1:0]      imem_rdata,
	output logic [npc_pkg::xlen-1:0]      imem_araddr,
	output logic                          imem_arvalid,
	output logic                          imem_rready,
	output logic                          retire_valid,
	output logic [npc_pkg::xlen-1:0]      retire_pc,
	output logic [npc_pkg::xlen-1:0]      retire_inst,
	output logic                          retire_wen,
	output logic [npc_pkg::regaddr_w-1:0] retire_rd,
	output logic [npc_pkg::xlen-1:0]      retire_wdata
);

	// fetch to decode
	logic fetch_valid;
	logic [npc_pkg::xlen-1:0] fetch_pc;
	logic [npc_pkg::xlen-1:0] fetch_inst;

	// decode to execute
	logic dec_valid;
	logic dec_accept;
	logic [npc_pkg::xlen-1:0] dec_pc;
	logic [npc_pkg::xlen-1:0] dec_inst;
	npc_pkg::npc_op_e dec_op;
	logic [npc_pkg::regaddr_w-1:0] dec_rd;
	logic [npc_pkg::regaddr_w-1:0] dec_rs1;
	logic [npc_pkg::regaddr_w-1:0] dec_rs2;
	logic [npc_pkg::xlen-1:0] dec_imm;

	// execute side
	logic exu_busy;
	logic redirect_valid;
	logic [npc_pkg::xlen-1:0] next_pc;
	logic rf_wen;
	logic [npc_pkg::regaddr_w-1:0] rf_waddr;
	logic [npc_pkg::xlen-1:0] rf_wdata;
	logic [npc_pkg::xlen-1:0] rs1_data;
	logic [npc_pkg::xlen-1:0] rs2_data;

	ifu ifu_i (
		.clk(clk),
		.rst(rst),
		.imem_arready(imem_arready),
		.imem_rvalid(imem_rvalid),
		.imem_rdata(imem_rdata),
		.redirect_valid(redirect_valid),
		.next_pc(next_pc),
		.dec_valid(dec_valid),
		.exu_busy(exu_busy),
		.imem_araddr(imem_araddr),
		.imem_arvalid(imem_arvalid),
		.imem_rready(imem_rready),
		.fetch_valid(fetch_valid),
		.fetch_pc(fetch_pc),
		.fetch_inst(fetch_inst)
	);

	idu idu_i (
		.clk(clk),
		.rst(rst),
		.fetch_valid(fetch_valid),
		.fetch_pc(fetch_pc),
		.fetch_inst(fetch_inst),
		.dec_accept(dec_accept),
		.dec_valid(dec_valid),
		.dec_pc(dec_pc),
		.dec_inst(dec_inst),
		.dec_op(dec_op),
		.dec_rd(dec_rd),
		.dec_rs1(dec_rs1),
		.dec_rs2(dec_rs2),
		.dec_imm(dec_imm)
	);

	exu exu_i (
		.clk(clk),
		.rst(rst),
		.dec_valid(dec_valid),
		.dec_pc(dec_pc),
		.dec_inst(dec_inst),
		.dec_op(dec_op),
		.dec_rd(dec_rd),
		.dec_rs1(dec_rs1),
		.dec_rs2(dec_rs2),
		.dec_imm(dec_imm),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.dec_accept(dec_accept),
		.exu_busy(exu_busy),
		.rf_wen(rf_wen),
		.rf_waddr(rf_waddr),
		.rf_wdata(rf_wdata),
		.redirect_valid(redirect_valid),
		.next_pc(next_pc),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_inst(retire_inst),
		.retire_wen(retire_wen),
		.retire_rd(retire_rd),
		.retire_wdata(retire_wdata)
	);

	regfile regfile_i (
		.clk(clk),
		.rst(rst),
		.raddr1(dec_rs1),
		.raddr2(dec_rs2),
		.wen(rf_wen),
		.waddr(rf_waddr),
		.wdata(rf_wdata),
		.rdata1(rs1_data),
		.rdata2(rs2_data)
	);

endmodule

// ==== logic/npc_pkg.sv ====
// npc shared definitions
package npc_pkg;

	localparam int unsigned xlen = 32;
	localparam int unsigned regaddr_w = 5;
	localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

	// opcodes of the supported subset
	localparam logic [6:0] op_reg = 7'b0110011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal = 7'b1101111;

	localparam logic [2:0] funct3_beq = 3'b000;
	localparam logic [2:0] funct3_bne = 3'b001;
	localparam logic [6:0] funct7_sub = 7'b0100000;

	// fetch state encodings
	localparam logic [2:0] ifu_idle = 3'd0;
	localparam logic [2:0] ifu_wait_ar = 3'd1;
	localparam logic [2:0] ifu_shaked_ar = 3'd2;
	localparam logic [2:0] ifu_wait_r = 3'd3;
	localparam logic [2:0] ifu_shaked_r = 3'd4;

	typedef enum logic [2:0] {
		exe_add,
		exe_sub,
		exe_lui,
		exe_beq,
		exe_bne,
		exe_jal,
		exe_nop
	} npc_op_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} npc_inst_r_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} npc_inst_i_t;

	// one instruction word, two decode views
	typedef union packed {
		npc_inst_r_t r;
		npc_inst_i_t i;
	} npc_inst_u;

	function automatic logic [xlen-1:0] imm_b(input logic [xlen-1:0] inst);
		return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	endfunction

	function automatic logic [xlen-1:0] imm_j(input logic [xlen-1:0] inst);
		return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
	endfunction

endpackage

// ==== logic/regfile.sv ====
// integer register file
module regfile (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [npc_pkg::regaddr_w-1:0] raddr1,
	input  logic [npc_pkg::regaddr_w-1:0] raddr2,
	input  logic                          wen,
	input  logic [npc_pkg::regaddr_w-1:0] waddr,
	input  logic [npc_pkg::xlen-1:0]      wdata,
	output logic [npc_pkg::xlen-1:0]      rdata1,
	output logic [npc_pkg::xlen-1:0]      rdata2
);

	logic [npc_pkg::xlen-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// x0 is hardwired
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== npc.f ====
logic/npc_pkg.sv
logic/regfile.sv
logic/ifu.sv
logic/idu.sv
logic/exu.sv
logic/npc_core.sv
test/npc_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -j 0 --top-module npc_tb -f npc.f -o npc_sim
./obj_dir/npc_sim

// ==== test/npc_tb.sv ====
// npc core testbench
module npc_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int timeout_cycles = 200;
	localparam int retire_target = 60;
	localparam int prog_len = 21;

	logic clk;
	logic rst;
	logic imem_arready;
	logic imem_rvalid;
	logic [31:0] imem_rdata;
	logic [31:0] imem_araddr;
	logic imem_arvalid;
	logic imem_rready;
	logic retire_valid;
	logic [31:0] retire_pc;
	logic [31:0] retire_inst;
	logic retire_wen;
	logic [4:0] retire_rd;
	logic [31:0] retire_wdata;

	// program image and architectural model state
	logic [31:0] prog [32];
	logic [31:0] ref_pc;
	logic [31:0] ref_regs [32];
	logic outstanding;

	npc_core npc_core_i (
		.clk(clk),
		.rst(rst),
		.imem_arready(imem_arready),
		.imem_rvalid(imem_rvalid),
		.imem_rdata(imem_rdata),
		.imem_araddr(imem_araddr),
		.imem_arvalid(imem_arvalid),
		.imem_rready(imem_rready),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_inst(retire_inst),
		.retire_wen(retire_wen),
		.retire_rd(retire_rd),
		.retire_wdata(retire_wdata)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("Errors found");
		$fatal(1, "%s", why);
	endtask

	task automatic compare_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			fail_run("a value seen at the core ports differs from the model");
		end
	endtask

	// instruction encoders
	function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, npc_pkg::op_reg};
	endfunction

	function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, npc_pkg::op_imm};
	endfunction

	function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
		return {imm, rd, npc_pkg::op_lui};
	endfunction

	function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], npc_pkg::op_branch};
	endfunction

	function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, npc_pkg::op_jal};
	endfunction

	task automatic load_program();
		prog[0] = addi_word(5'd1, 5'd0, 12'd5);
		prog[1] = addi_word(5'd2, 5'd0, -12'd3);
		prog[2] = r_word(7'b0, 3'b000, 5'd3, 5'd1, 5'd2);
		prog[3] = r_word(npc_pkg::funct7_sub, 3'b000, 5'd4, 5'd1, 5'd2);
		prog[4] = lui_word(5'd5, 20'h12345);
		// write to x0, then read it back
		prog[5] = addi_word(5'd0, 5'd1, 12'd7);
		prog[6] = r_word(7'b0, 3'b000, 5'd6, 5'd0, 5'd1);
		prog[7] = branch_word(npc_pkg::funct3_beq, 5'd1, 5'd1, 13'd8);
		prog[8] = addi_word(5'd7, 5'd0, 12'd1);
		prog[9] = branch_word(npc_pkg::funct3_bne, 5'd1, 5'd1, 13'd8);
		prog[10] = branch_word(npc_pkg::funct3_bne, 5'd1, 5'd2, 13'd8);
		prog[11] = addi_word(5'd7, 5'd0, 12'd2);
		prog[12] = branch_word(npc_pkg::funct3_beq, 5'd3, 5'd4, 13'd8);
		// OR is outside the subset
		prog[13] = r_word(7'b0, 3'b110, 5'd8, 5'd1, 5'd2);
		prog[14] = jal_word(5'd9, 21'd8);
		prog[15] = addi_word(5'd7, 5'd0, 12'd3);
		// countdown loop of three turns
		prog[16] = addi_word(5'd12, 5'd0, 12'd3);
		prog[17] = addi_word(5'd12, 5'd12, -12'd1);
		prog[18] = branch_word(npc_pkg::funct3_bne, 5'd12, 5'd0, -13'd4);
		prog[19] = r_word(7'b0, 3'b000, 5'd13, 5'd12, 5'd5);
		prog[20] = jal_word(5'd0, 21'd0);
	endtask

	// steps the architectural model by one instruction
	function automatic void ref_step(output logic [31:0] e_pc, output logic [31:0] e_inst,
			output logic e_wen, output logic [4:0] e_rd, output logic [31:0] e_wdata);
		logic [31:0] idx;
		logic [31:0] inst;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] pc_next;
		logic writes;
		idx = (ref_pc - npc_pkg::reset_pc) >> 2;
		inst = prog[idx[4:0]];
		a = ref_regs[inst[19:15]];
		b = ref_regs[inst[24:20]];
		pc_next = ref_pc + 32'd4;
		writes = 1'b0;
		e_wdata = '0;
		case (inst[6:0])
			npc_pkg::op_reg: begin
				if (inst[14:12] == 3'b000 && inst[31:25] == 7'b0) begin
					writes = 1'b1;
					e_wdata = a + b;
				end else if (inst[14:12] == 3'b000 && inst[31:25] == npc_pkg::funct7_sub) begin
					writes = 1'b1;
					e_wdata = a - b;
				end
			end
			npc_pkg::op_imm: begin
				if (inst[14:12] == 3'b000) begin
					writes = 1'b1;
					e_wdata = a + {{20{inst[31]}}, inst[31:20]};
				end
			end
			npc_pkg::op_lui: begin
				writes = 1'b1;
				e_wdata = {inst[31:12], 12'b0};
			end
			npc_pkg::op_branch: begin
				if ((inst[14:12] == npc_pkg::funct3_beq && a == b) ||
						(inst[14:12] == npc_pkg::funct3_bne && a != b))
					pc_next = ref_pc + npc_pkg::imm_b(inst);
			end
			npc_pkg::op_jal: begin
				writes = 1'b1;
				e_wdata = ref_pc + 32'd4;
				pc_next = ref_pc + npc_pkg::imm_j(inst);
			end
			default: writes = 1'b0;
		endcase
		e_pc = ref_pc;
		e_inst = inst;
		e_rd = writes ? inst[11:7] : 5'd0;
		e_wen = (e_rd != 5'd0);
		if (e_wen)
			ref_regs[e_rd] = e_wdata;
		ref_pc = pc_next;
	endfunction

	initial begin
		void'($urandom(32'hb047ef6f));
		rst <= 1'b1;
		outstanding = 1'b0;
		ref_pc = npc_pkg::reset_pc;
		for (int i = 0; i < 32; i++)
			ref_regs[i] = '0;
		load_program();
		repeat (10) @(posedge clk);
		rst <= 1'b0;
	end

	// instruction memory with random handshake delays
	initial begin : responder
		int wait_n;
		int delay;
		logic [31:0] idx;
		imem_arready <= 1'b0;
		imem_rvalid <= 1'b0;
		imem_rdata <= '0;
		wait_n = 0;
		while (rst !== 1'b0) begin
			@(posedge clk);
			wait_n++;
			if (wait_n > timeout_cycles)
				fail_run("reset was never released");
		end
		forever begin
			wait_n = 0;
			do begin
				@(posedge clk);
				wait_n++;
				if (wait_n > timeout_cycles)
					fail_run("the core stopped requesting instructions");
			end while (imem_arvalid !== 1'b1);
			delay = $urandom_range(4, 0);
			repeat (delay) @(posedge clk);
			imem_arready <= 1'b1;
			wait_n = 0;
			do begin
				@(posedge clk);
				wait_n++;
				if (wait_n > timeout_cycles)
					fail_run("the address handshake never completed");
			end while (!(imem_arvalid === 1'b1 && imem_arready === 1'b1));
			imem_arready <= 1'b0;
			// one instruction in flight at a time
			if (outstanding)
				fail_run("a second address was accepted before the previous retire");
			outstanding = 1'b1;
			compare_value("fetch_addr", ref_pc, imem_araddr);
			idx = (imem_araddr - npc_pkg::reset_pc) >> 2;
			if (idx >= prog_len)
				fail_run("fetch address lies outside the program");
			delay = $urandom_range(4, 0);
			repeat (delay) @(posedge clk);
			imem_rvalid <= 1'b1;
			imem_rdata <= prog[idx[4:0]];
			wait_n = 0;
			do begin
				@(posedge clk);
				wait_n++;
				if (wait_n > timeout_cycles)
					fail_run("the data handshake never completed");
			end while (!(imem_rvalid === 1'b1 && imem_rready === 1'b1));
			imem_rvalid <= 1'b0;
		end
	end

	initial begin : compare
		int wait_n;
		logic [31:0] e_pc;
		logic [31:0] e_inst;
		logic [31:0] e_wdata;
		logic e_wen;
		logic [4:0] e_rd;
		for (int n = 0; n < retire_target; n++) begin
			wait_n = 0;
			do begin
				@(posedge clk);
				wait_n++;
				if (wait_n > timeout_cycles)
					fail_run("no instruction retired in time");
			end while (retire_valid !== 1'b1);
			ref_step(e_pc, e_inst, e_wen, e_rd, e_wdata);
			compare_value("retire_pc", e_pc, retire_pc);
			compare_value("retire_inst", e_inst, retire_inst);
			compare_value("retire_wen", {31'b0, e_wen}, {31'b0, retire_wen});
			compare_value("retire_rd", {27'b0, e_rd}, {27'b0, retire_rd});
			// write data only matters when a register is written
			if (e_wen)
				compare_value("retire_wdata", e_wdata, retire_wdata);
			outstanding = 1'b0;
		end
		$display("No errors");
		$finish;
	end

endmodule
